//--- verilog/lsq_defs.svh
//////////////////////////////
// Load/store queue sizing
//////////////////////////////

`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// Queue depth, must stay a power of two for pointer wrap
`define LSQ_ENTRIES   32
`define LSQ_PTR_BITS  5

// Data and address width
`define XLEN          64

// Reorder-buffer tag width
`define ROB_TAG_BITS  5

// Memory response tag width, tag zero means no tag
`define MEM_TAG_BITS  4

// Data memory depth in 64-bit words
`define MEM_WORDS     256

// Cycles from load acceptance to data return
`define MEM_LATENCY   4

`endif

//--- verilog/lsq_pkg.sv
//////////////////////////////
// Queue and processor types
//////////////////////////////

`default_nettype none

`include "lsq_defs.svh"

package lsq_pkg;

  typedef enum logic {
    MEM_OP_LOAD,
    MEM_OP_STORE
  } mem_op_t;

  // One dispatch slot
  typedef struct packed {
    logic                     valid;
    logic [`ROB_TAG_BITS-1:0] rob_tag;
    mem_op_t                  op;
  } alloc_t;

  // One execute result bus
  typedef struct packed {
    logic                     valid;
    logic [`ROB_TAG_BITS-1:0] rob_tag;
    logic [`XLEN-1:0]         address;
    logic [`XLEN-1:0]         value;
  } ex_result_t;

  // Reorder-buffer head slot
  typedef struct packed {
    logic                     valid;
    logic [`ROB_TAG_BITS-1:0] rob_tag;
  } rob_head_t;

  // Load data or store address of a retired op
  typedef struct packed {
    logic                     valid;
    logic [`ROB_TAG_BITS-1:0] rob_tag;
    mem_op_t                  op;
    logic [`XLEN-1:0]         result;
  } completion_t;

endpackage

`default_nettype wire

//--- verilog/mem_bus_pkg.sv
//////////////////////////////
// Data memory bus types
//////////////////////////////

`default_nettype none

`include "lsq_defs.svh"

package mem_bus_pkg;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  typedef struct packed {
    bus_cmd_t         command;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] data;
  } mem_req_t;

  // Acceptance tag in the request cycle, load return later
  typedef struct packed {
    logic [`MEM_TAG_BITS-1:0] response;
    logic [`MEM_TAG_BITS-1:0] tag;
    logic [`XLEN-1:0]         data;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- verilog/lsq_entry.sv
//////////////////////////////
// Load/store queue slot
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsq_defs.svh"

module lsq_entry (
  input  wire logic                       clock,
  input  wire logic                       reset,
  input  wire logic                       clear,
  input  wire lsq_pkg::alloc_t            alloc,
  input  wire lsq_pkg::ex_result_t        ex_0,
  input  wire lsq_pkg::ex_result_t        ex_1,
  input  wire lsq_pkg::rob_head_t         rob_head_0,
  input  wire lsq_pkg::rob_head_t         rob_head_1,
  output logic [`ROB_TAG_BITS-1:0]        entry_tag,
  output lsq_pkg::mem_op_t                entry_op,
  output logic [`XLEN-1:0]                entry_address,
  output logic [`XLEN-1:0]                entry_value,
  output logic                            entry_ready
);

  logic valid;
  logic addr_known;
  logic head_met;
  logic hit_0;
  logic hit_1;
  logic head_hit;

  // Execute buses only match an occupied slot
  assign hit_0 = valid && ex_0.valid && (ex_0.rob_tag == entry_tag);
  assign hit_1 = valid && ex_1.valid && (ex_1.rob_tag == entry_tag);

  // Head match counts only once the address is in
  assign head_hit = addr_known &&
                    ((rob_head_0.valid && (rob_head_0.rob_tag == entry_tag)) ||
                     (rob_head_1.valid && (rob_head_1.rob_tag == entry_tag)));

  //////////////////////////////
  // Slot state
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      valid      <= 1'b0;
      addr_known <= 1'b0;
      head_met   <= 1'b0;
    end else if (alloc.valid) begin
      valid      <= 1'b1;
      addr_known <= 1'b0;
      head_met   <= 1'b0;
    end else begin
      if (hit_0 || hit_1) begin
        addr_known <= 1'b1;
      end
      if (head_hit && (entry_op == lsq_pkg::MEM_OP_STORE)) begin
        head_met <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Payload
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (alloc.valid) begin
      entry_tag <= alloc.rob_tag;
      entry_op  <= alloc.op;
    end
    // Bus 0 wins if both carry our tag
    if (hit_0) begin
      entry_address <= ex_0.address;
      entry_value   <= ex_0.value;
    end else if (hit_1) begin
      entry_address <= ex_1.address;
      entry_value   <= ex_1.value;
    end
  end

  // Stores wait for the reorder buffer, loads only for the address
  assign entry_ready = valid && addr_known &&
                       ((entry_op == lsq_pkg::MEM_OP_LOAD) || head_met || head_hit);

endmodule

`default_nettype wire

//--- verilog/load_store_queue.sv
//////////////////////////////
// Two-wide load/store queue
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsq_defs.svh"

module load_store_queue (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire lsq_pkg::alloc_t        alloc_0,
  input  wire lsq_pkg::alloc_t        alloc_1,
  input  wire lsq_pkg::ex_result_t    ex_0,
  input  wire lsq_pkg::ex_result_t    ex_1,
  input  wire lsq_pkg::rob_head_t     rob_head_0,
  input  wire lsq_pkg::rob_head_t     rob_head_1,
  input  wire mem_bus_pkg::mem_rsp_t  mem_rsp,
  output mem_bus_pkg::mem_req_t       mem_req,
  output lsq_pkg::completion_t        completion,
  output logic                        queue_full
);

  localparam int unsigned count_bits = `LSQ_PTR_BITS + 1;

  lsq_pkg::alloc_t          slot_alloc   [`LSQ_ENTRIES];
  logic [`LSQ_ENTRIES-1:0]  slot_clear;
  logic [`LSQ_ENTRIES-1:0]  slot_ready;
  logic [`ROB_TAG_BITS-1:0] slot_tag     [`LSQ_ENTRIES];
  lsq_pkg::mem_op_t         slot_op      [`LSQ_ENTRIES];
  logic [`XLEN-1:0]         slot_address [`LSQ_ENTRIES];
  logic [`XLEN-1:0]         slot_value   [`LSQ_ENTRIES];

  logic [`LSQ_PTR_BITS-1:0] head;
  logic [`LSQ_PTR_BITS-1:0] tail;
  logic [`LSQ_PTR_BITS-1:0] entry_1;
  logic [`LSQ_PTR_BITS-1:0] entry_2;
  logic [count_bits-1:0]    occupancy;
  logic [1:0]               alloc_count;
  logic [`MEM_TAG_BITS-1:0] waiting_tag;
  logic                     store_accept;
  logic                     load_return;
  logic                     retire;

  //////////////////////////////
  // Allocation
  //////////////////////////////

  assign entry_1     = tail + `LSQ_PTR_BITS'(1);
  assign entry_2     = tail + `LSQ_PTR_BITS'(2);
  assign alloc_count = {1'b0, alloc_0.valid} + {1'b0, alloc_1.valid};

  // Older valid op always lands in the first free slot
  always_comb begin
    for (int i = 0; i < `LSQ_ENTRIES; i++) begin
      slot_alloc[i] = '0;
    end
    if (alloc_0.valid) begin
      slot_alloc[entry_1] = alloc_0;
      if (alloc_1.valid) begin
        slot_alloc[entry_2] = alloc_1;
      end
    end else if (alloc_1.valid) begin
      slot_alloc[entry_1] = alloc_1;
    end
  end

  for (genvar i = 0; i < `LSQ_ENTRIES; i++) begin : g_slot
    assign slot_clear[i] = retire && (head == `LSQ_PTR_BITS'(i));

    lsq_entry u_entry (
      .clock         (clock),
      .reset         (reset),
      .clear         (slot_clear[i]),
      .alloc         (slot_alloc[i]),
      .ex_0          (ex_0),
      .ex_1          (ex_1),
      .rob_head_0    (rob_head_0),
      .rob_head_1    (rob_head_1),
      .entry_tag     (slot_tag[i]),
      .entry_op      (slot_op[i]),
      .entry_address (slot_address[i]),
      .entry_value   (slot_value[i]),
      .entry_ready   (slot_ready[i])
    );
  end

  //////////////////////////////
  // Issue
  //////////////////////////////

  // Nothing leaves while a load is in flight
  always_comb begin
    mem_req.command = mem_bus_pkg::BUS_NONE;
    if (slot_ready[head] && (waiting_tag == '0)) begin
      if (slot_op[head] == lsq_pkg::MEM_OP_LOAD) begin
        mem_req.command = mem_bus_pkg::BUS_LOAD;
      end else begin
        mem_req.command = mem_bus_pkg::BUS_STORE;
      end
    end
    mem_req.address = slot_address[head];
    mem_req.data    = slot_value[head];
  end

  assign store_accept = (mem_req.command == mem_bus_pkg::BUS_STORE) &&
                        (mem_rsp.response != '0);
  assign load_return  = (waiting_tag != '0) && (mem_rsp.tag == waiting_tag);
  assign retire       = store_accept || load_return;

  always_ff @(posedge clock) begin
    if (reset) begin
      waiting_tag <= '0;
    end else if (load_return) begin
      waiting_tag <= '0;
    end else if (mem_req.command == mem_bus_pkg::BUS_LOAD) begin
      waiting_tag <= mem_rsp.response;
    end
  end

  //////////////////////////////
  // Retirement
  //////////////////////////////

  always_comb begin
    completion.valid   = retire;
    completion.rob_tag = slot_tag[head];
    completion.op      = slot_op[head];
    completion.result  = load_return ? mem_rsp.data : slot_address[head];
  end

  // Head starts one past tail, so entry_1 is the first slot used
  always_ff @(posedge clock) begin
    if (reset) begin
      head      <= `LSQ_PTR_BITS'(1);
      tail      <= '0;
      occupancy <= '0;
    end else begin
      tail      <= tail + `LSQ_PTR_BITS'(alloc_count);
      occupancy <= occupancy + count_bits'(alloc_count) - count_bits'(retire);
      if (retire) begin
        head <= head + `LSQ_PTR_BITS'(1);
      end
    end
  end

  // Fewer than two free slots
  assign queue_full = occupancy > count_bits'(`LSQ_ENTRIES - 2);

endmodule

`default_nettype wire

//--- verilog/tagged_data_memory.sv
//////////////////////////////
// Tagged data memory
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsq_defs.svh"

module tagged_data_memory (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire mem_bus_pkg::mem_req_t  mem_req,
  output mem_bus_pkg::mem_rsp_t       mem_rsp
);

  localparam int unsigned index_bits = $clog2(`MEM_WORDS);

  logic [`XLEN-1:0]         words     [`MEM_WORDS];
  logic [`MEM_WORDS-1:0]    written;
  logic [index_bits-1:0]    index;
  logic [`XLEN-1:0]         read_data;
  logic                     accept;
  logic                     store;
  logic [`MEM_TAG_BITS-1:0] next_tag;
  logic [`MEM_TAG_BITS-1:0] pipe_tag  [`MEM_LATENCY];
  logic [`XLEN-1:0]         pipe_data [`MEM_LATENCY];

  // Word index above the byte offset, upper bits wrap
  assign index  = mem_req.address[index_bits+2:3];
  assign accept = mem_req.command != mem_bus_pkg::BUS_NONE;
  assign store  = mem_req.command == mem_bus_pkg::BUS_STORE;

  // Never-written words read as zero
  assign read_data = written[index] ? words[index] : '0;

  always_comb begin
    mem_rsp.response = accept ? next_tag : '0;
    mem_rsp.tag      = pipe_tag[`MEM_LATENCY-1];
    mem_rsp.data     = pipe_data[`MEM_LATENCY-1];
  end

  //////////////////////////////
  // Tags and storage
  //////////////////////////////

  // Counts 1..max then back to 1
  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= `MEM_TAG_BITS'(1);
    end else if (accept) begin
      if (next_tag == '1) begin
        next_tag <= `MEM_TAG_BITS'(1);
      end else begin
        next_tag <= next_tag + `MEM_TAG_BITS'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store) begin
      words[index] <= mem_req.data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      written <= '0;
    end else if (store) begin
      written[index] <= 1'b1;
    end
  end

  //////////////////////////////
  // Load return pipeline
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < `MEM_LATENCY; k++) begin
        pipe_tag[k] <= '0;
      end
    end else begin
      pipe_tag[0] <= (mem_req.command == mem_bus_pkg::BUS_LOAD) ? next_tag : '0;
      for (int k = 1; k < `MEM_LATENCY; k++) begin
        pipe_tag[k] <= pipe_tag[k-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    pipe_data[0] <= read_data;
    for (int k = 1; k < `MEM_LATENCY; k++) begin
      pipe_data[k] <= pipe_data[k-1];
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_subsystem_top.sv
//////////////////////////////
// Memory subsystem top
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_top (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire lsq_pkg::alloc_t      alloc_0,
  input  wire lsq_pkg::alloc_t      alloc_1,
  input  wire lsq_pkg::ex_result_t  ex_0,
  input  wire lsq_pkg::ex_result_t  ex_1,
  input  wire lsq_pkg::rob_head_t   rob_head_0,
  input  wire lsq_pkg::rob_head_t   rob_head_1,
  output lsq_pkg::completion_t      completion,
  output logic                      queue_full
);

  mem_bus_pkg::mem_req_t mem_req;
  mem_bus_pkg::mem_rsp_t mem_rsp;

  load_store_queue u_lsq (
    .clock      (clock),
    .reset      (reset),
    .alloc_0    (alloc_0),
    .alloc_1    (alloc_1),
    .ex_0       (ex_0),
    .ex_1       (ex_1),
    .rob_head_0 (rob_head_0),
    .rob_head_1 (rob_head_1),
    .mem_rsp    (mem_rsp),
    .mem_req    (mem_req),
    .completion (completion),
    .queue_full (queue_full)
  );

  // Accepts every request in its own cycle
  tagged_data_memory u_dmem (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

`default_nettype wire

//--- testbench/mem_subsystem_tb.sv
//////////////////////////////
// Memory subsystem testbench
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "lsq_defs.svh"

module mem_subsystem_tb;

  // About 364 ops at 6 cycles worst case plus gating and fill waits
  localparam int max_cycles = 4000;
  localparam int max_ops    = 512;
  localparam int fill_limit = `LSQ_ENTRIES - 1;

  logic                 clock = 1'b0;
  logic                 reset;
  lsq_pkg::alloc_t      alloc_0;
  lsq_pkg::alloc_t      alloc_1;
  lsq_pkg::ex_result_t  ex_0;
  lsq_pkg::ex_result_t  ex_1;
  lsq_pkg::rob_head_t   rob_head_0;
  lsq_pkg::rob_head_t   rob_head_1;
  lsq_pkg::completion_t completion;
  logic                 queue_full;

  // Program-order op list
  lsq_pkg::mem_op_t         op_kind    [max_ops];
  logic [`ROB_TAG_BITS-1:0] op_tag     [max_ops];
  logic [`XLEN-1:0]         op_address [max_ops];
  logic [`XLEN-1:0]         op_value   [max_ops];
  bit                       ex_sent    [max_ops];
  bit [7:0]                 shadow     [2048];
  logic [63:0]              expected_result;

  int    op_count      = 0;
  int    next_alloc    = 0;
  int    retired_count = 0;
  int    model_occ     = 0;
  int    cycle_count   = 0;
  int    gate_index    = -1;
  bit    hold_ex       = 1'b0;
  bit    checking      = 1'b0;
  string test_name     = "reset_state";

  mem_subsystem_top UUT (
    .clock      (clock),
    .reset      (reset),
    .alloc_0    (alloc_0),
    .alloc_1    (alloc_1),
    .ex_0       (ex_0),
    .ex_1       (ex_1),
    .rob_head_0 (rob_head_0),
    .rob_head_1 (rob_head_1),
    .completion (completion),
    .queue_full (queue_full)
  );

  always #5 clock = ~clock;

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[FAIL] %s %s expected %h actual %h", test_name, what, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_error(input string message);
    $display("[ERROR] %s: %s", test_name, message);
    stop_with_failure();
  endtask

  // Expected completion from the byte shadow
  function automatic logic [63:0] reference_result(input int index);
    logic [10:0] base;
    logic [63:0] word;
    base = op_address[index][10:0];
    word = '0;
    if (op_kind[index] == lsq_pkg::MEM_OP_STORE) begin
      for (int b = 0; b < 8; b++) begin
        shadow[base + 11'(b)] = op_value[index][8*b +: 8];
      end
      return op_address[index];
    end
    for (int b = 0; b < 8; b++) begin
      word[8*b +: 8] = shadow[base + 11'(b)];
    end
    return word;
  endfunction

  task automatic add_op(input lsq_pkg::mem_op_t kind, input logic [63:0] address,
                        input logic [63:0] value);
    op_kind[op_count]    = kind;
    op_tag[op_count]     = `ROB_TAG_BITS'(op_count);
    op_address[op_count] = address;
    op_value[op_count]   = value;
    op_count++;
  endtask

  task automatic add_random_ops(input int count, input int span);
    lsq_pkg::mem_op_t kind;
    for (int n = 0; n < count; n++) begin
      kind = ($urandom % 2) ? lsq_pkg::MEM_OP_STORE : lsq_pkg::MEM_OP_LOAD;
      add_op(kind, 64'($urandom % span) << 3, {$urandom, $urandom});
    end
  endtask

  //////////////////////////////
  // Dispatch, execute, ROB model
  //////////////////////////////

  task automatic drive_cycles(input int limit);
    lsq_pkg::alloc_t     a [2];
    lsq_pkg::ex_result_t e [2];
    lsq_pkg::rob_head_t  head;
    int                  cand [$];
    int                  alloc_mark;
    int                  pick;
    int                  scan;
    bit                  found;
    int                  n;
    n = 0;
    while (retired_count < op_count && n < limit) begin
      @(posedge clock);
      alloc_mark = next_alloc;
      for (int s = 0; s < 2; s++) begin
        a[s] = '0;
        if (next_alloc < op_count && next_alloc - retired_count < fill_limit) begin
          a[s].valid   = 1'b1;
          a[s].rob_tag = op_tag[next_alloc];
          a[s].op      = op_kind[next_alloc];
          next_alloc++;
        end
      end
      // Shuffled results for slots already allocated
      cand.delete();
      for (int i = retired_count; i < alloc_mark; i++) begin
        if (!ex_sent[i]) begin
          cand.push_back(i);
        end
      end
      for (int bus = 0; bus < 2; bus++) begin
        e[bus] = '0;
        if (!hold_ex && cand.size() > 0 && ($urandom % 4) != 0) begin
          pick = $urandom % cand.size();
          e[bus].valid   = 1'b1;
          e[bus].rob_tag = op_tag[cand[pick]];
          e[bus].address = op_address[cand[pick]];
          e[bus].value   = op_value[cand[pick]];
          ex_sent[cand[pick]] = 1'b1;
          cand.delete(pick);
        end
      end
      // Oldest unretired store goes to the ROB head once executed
      head  = '0;
      found = 1'b0;
      scan  = retired_count;
      while (!found && scan < alloc_mark) begin
        if (op_kind[scan] == lsq_pkg::MEM_OP_STORE) begin
          found = 1'b1;
          if (ex_sent[scan] && scan != gate_index) begin
            head.valid   = 1'b1;
            head.rob_tag = op_tag[scan];
          end
        end
        scan++;
      end
      alloc_0    <= a[0];
      alloc_1    <= a[1];
      ex_0       <= e[0];
      ex_1       <= e[1];
      rob_head_0 <= head;
      n++;
    end
    @(posedge clock);
    alloc_0    <= '0;
    alloc_1    <= '0;
    ex_0       <= '0;
    ex_1       <= '0;
    rob_head_0 <= '0;
  endtask

  //////////////////////////////
  // Completion checker
  //////////////////////////////

  always @(negedge clock) begin
    if (checking) begin
      assert (queue_full == (model_occ >= fill_limit))
        else report_mismatch("queue_full", 64'(model_occ >= fill_limit), 64'(queue_full));
      if (completion.valid) begin
        assert (retired_count < op_count)
          else report_error("completion pulse with no operation outstanding");
        expected_result = reference_result(retired_count);
        assert (completion.rob_tag == op_tag[retired_count])
          else report_mismatch("rob_tag", 64'(op_tag[retired_count]), 64'(completion.rob_tag));
        assert (completion.op == op_kind[retired_count])
          else report_mismatch("op", 64'(op_kind[retired_count]), 64'(completion.op));
        assert (completion.result == expected_result)
          else report_mismatch("result", expected_result, completion.result);
        retired_count++;
      end
      model_occ = model_occ + int'(alloc_0.valid) + int'(alloc_1.valid)
                  - int'(completion.valid);
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, %0d of %0d operations retired",
               cycle_count, retired_count, op_count);
      stop_with_failure();
    end
  end

  initial begin
    void'($urandom(51283));
    reset      = 1'b1;
    alloc_0    = '0;
    alloc_1    = '0;
    ex_0       = '0;
    ex_1       = '0;
    rob_head_0 = '0;
    rob_head_1 = '0;
    @(posedge clock);
    checking = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // Loads from never-written words
    add_op(lsq_pkg::MEM_OP_LOAD, 64'h40, 64'h0);
    add_op(lsq_pkg::MEM_OP_LOAD, 64'h7f8, 64'h0);
    drive_cycles(max_cycles);

    test_name = "store_then_load";
    add_op(lsq_pkg::MEM_OP_STORE, 64'h40, 64'h1122_3344_5566_7788);
    add_op(lsq_pkg::MEM_OP_LOAD, 64'h40, 64'h0);
    drive_cycles(max_cycles);

    test_name = "two_wide";
    add_random_ops(24, 8);
    drive_cycles(max_cycles);

    test_name = "store_gating";
    add_op(lsq_pkg::MEM_OP_LOAD, 64'h20, 64'h0);
    gate_index = op_count;
    add_op(lsq_pkg::MEM_OP_STORE, 64'h20, 64'hdead_beef_0bad_f00d);
    add_op(lsq_pkg::MEM_OP_LOAD, 64'h20, 64'h0);
    add_op(lsq_pkg::MEM_OP_STORE, 64'h28, 64'h0123_4567_89ab_cdef);
    add_op(lsq_pkg::MEM_OP_LOAD, 64'h28, 64'h0);
    drive_cycles(40);
    assert (retired_count == gate_index)
      else report_mismatch("retired count", 64'(gate_index), 64'(retired_count));
    gate_index = -1;
    drive_cycles(max_cycles);

    test_name = "full_queue";
    hold_ex   = 1'b1;
    add_random_ops(fill_limit, 32);
    drive_cycles(20);
    @(negedge clock);
    assert (queue_full) else report_mismatch("queue_full", 64'h1, 64'(queue_full));
    hold_ex = 1'b0;
    drive_cycles(max_cycles);
    @(negedge clock);
    assert (!queue_full) else report_mismatch("queue_full", 64'h0, 64'(queue_full));

    test_name = "random_run";
    add_random_ops(300, 32);
    drive_cycles(max_cycles);
    repeat (2) @(posedge clock);

    if (retired_count == op_count) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_error("operations left unretired at end of run");
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
verilog/lsq_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lsq_entry.sv
verilog/load_store_queue.sv
verilog/tagged_data_memory.sv
verilog/mem_subsystem_top.sv
testbench/mem_subsystem_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

export_include_dirs:
  - verilog

sources:
  # Packages first, then the design bottom up
  - files:
      - verilog/lsq_pkg.sv
      - verilog/mem_bus_pkg.sv
      - verilog/lsq_entry.sv
      - verilog/load_store_queue.sv
      - verilog/tagged_data_memory.sv
      - verilog/mem_subsystem_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/mem_subsystem_tb.sv
